//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_bus_if.sv
  - rv_ctrl.sv
  - rv_regfile.sv
  - rv_exu.sv
  - rv_xbar.sv
  - rv_clint.sv
  - rv_core_top.sv
  - target: test
    files:
      - rv_core_asserts.sv
      - tb_rv_core.sv

//--- all.f
rv_pkg.sv
rv_bus_if.sv
rv_ctrl.sv
rv_regfile.sv
rv_exu.sv
rv_xbar.sv
rv_clint.sv
rv_core_top.sv
rv_core_asserts.sv
tb_rv_core.sv

//--- rv_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rv_bus_if;
	import rv_pkg::*;

	logic            req_valid;
	logic            req_ready;
	logic [xlen-1:0] addr;
	logic            write;
	logic [xlen-1:0] wdata;
	logic [3:0]      wstrb;
	logic            rsp_valid;
	logic            rsp_ready;
	logic [xlen-1:0] rdata;
	logic            err;

	modport master (
		output req_valid, addr, write, wdata, wstrb, rsp_ready,
		input  req_ready, rsp_valid, rdata, err
	);

	modport slave (
		input  req_valid, addr, write, wdata, wstrb, rsp_ready,
		output req_ready, rsp_valid, rdata, err
	);

endinterface

`default_nettype wire

//--- rv_clint.sv
`timescale 1ns/1ps
`default_nettype none

module rv_clint (
	input  logic    clock,
	input  logic    reset,
	rv_bus_if.slave bus
);

	logic [63:0] mtime;
	logic        req_fire;

	assign bus.req_ready = !bus.rsp_valid; // Idle whenever no response is pending.
	assign req_fire = bus.req_valid && bus.req_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime <= 64'd0;
			bus.rsp_valid <= 1'b0;
		end else begin
			mtime <= mtime + 64'd1;
			if (req_fire)
				bus.rsp_valid <= 1'b1;
			else if (bus.rsp_ready)
				bus.rsp_valid <= 1'b0;
		end
	end

	// The timer is read only.
	always_ff @(posedge clock) begin
		if (req_fire) begin
			bus.rdata <= bus.addr[2] ? mtime[63:32] : mtime[31:0];
			bus.err <= bus.write;
		end
	end

endmodule

`default_nettype wire

//--- rv_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_asserts (
	input logic        clock,
	input logic        reset,
	input logic        awvalid,
	input logic        awready,
	input logic [31:0] awaddr,
	input logic        wvalid,
	input logic        wready,
	input logic [31:0] wdata,
	input logic [3:0]  wstrb,
	input logic        bready,
	input logic        arvalid,
	input logic        arready,
	input logic [31:0] araddr,
	input logic        rready,
	input logic        retire_valid,
	input logic        trap
);

	int fail_count = 0;

	reset_state: assert property (@(posedge clock)
		reset |=> !awvalid && !wvalid && !arvalid && !bready && !rready && !retire_valid && !trap)
	else begin
		$error("Outputs were not idle right after reset.");
		fail_count++;
	end

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr))
	else begin
		$error("awvalid or awaddr changed before awready.");
		fail_count++;
	end

	w_hold: assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
	else begin
		$error("wvalid or its payload changed before wready.");
		fail_count++;
	end

	ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
	else begin
		$error("arvalid or araddr changed before arready.");
		fail_count++;
	end

	// A read and a write are never in flight together.
	one_outstanding: assert property (@(posedge clock) disable iff (reset)
		!(arvalid || rready) || !(awvalid || wvalid || bready))
	else begin
		$error("A read and a write were outstanding at the same time.");
		fail_count++;
	end

	retire_pulse: assert property (@(posedge clock) disable iff (reset)
		retire_valid |=> !retire_valid)
	else begin
		$error("retire_valid stayed high for two cycles.");
		fail_count++;
	end

	trap_sticky: assert property (@(posedge clock) disable iff (reset) trap |=> trap)
	else begin
		$error("trap fell without a reset.");
		fail_count++;
	end

	quiet_after_trap: assert property (@(posedge clock) disable iff (reset)
		trap |-> !arvalid && !awvalid)
	else begin
		$error("The core issued a bus request after the trap.");
		fail_count++;
	end

endmodule

`default_nettype wire

//--- rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
	parameter logic [31:0] reset_pc = 32'h3000_0000,
	parameter logic [31:0] clint_base = 32'h0200_0000
) (
	input  logic        clock,
	input  logic        reset,
	output logic        awvalid,
	input  logic        awready,
	output logic [31:0] awaddr,
	output logic        wvalid,
	input  logic        wready,
	output logic [31:0] wdata,
	output logic [3:0]  wstrb,
	input  logic        bvalid,
	output logic        bready,
	input  logic [1:0]  bresp,
	output logic        arvalid,
	input  logic        arready,
	output logic [31:0] araddr,
	input  logic        rvalid,
	output logic        rready,
	input  logic [31:0] rdata,
	input  logic [1:0]  rresp,
	output logic        retire_valid,
	output logic [31:0] retire_pc,
	output logic        trap
);
	import rv_pkg::*;

	inst_t       inst;
	logic [31:0] pc;
	logic [31:0] exu_result;
	logic [31:0] exu_mem_addr;
	logic [31:0] next_pc;
	logic [31:0] src1;
	logic [31:0] src2;
	logic        rf_wen;
	logic [31:0] rf_wdata;

	rv_bus_if core_bus ();
	rv_bus_if clint_bus ();

	rv_ctrl #(
		.reset_pc(reset_pc)
	) ctrl_i (
		.clock(clock),
		.reset(reset),
		.bus(core_bus.master),
		.inst(inst),
		.pc(pc),
		.exu_result(exu_result),
		.exu_mem_addr(exu_mem_addr),
		.next_pc(next_pc),
		.rf_wen(rf_wen),
		.rf_wdata(rf_wdata),
		.store_data(src2),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.trap(trap)
	);

	rv_regfile regfile_i (
		.clock(clock),
		.raddr1(inst.r.rs1),
		.raddr2(inst.r.rs2),
		.rdata1(src1),
		.rdata2(src2),
		.wen(rf_wen),
		.waddr(inst.r.rd),
		.wdata(rf_wdata)
	);

	rv_exu exu_i (
		.inst(inst),
		.pc(pc),
		.src1(src1),
		.src2(src2),
		.result(exu_result),
		.mem_addr(exu_mem_addr),
		.next_pc(next_pc)
	);

	rv_xbar #(
		.clint_base(clint_base)
	) xbar_i (
		.clock(clock),
		.reset(reset),
		.core_bus(core_bus.slave),
		.clint_bus(clint_bus.master),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.wstrb(wstrb),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp)
	);

	rv_clint clint_i (
		.clock(clock),
		.reset(reset),
		.bus(clint_bus.slave)
	);

endmodule

`default_nettype wire

//--- rv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl #(
	parameter logic [31:0] reset_pc = 32'h3000_0000
) (
	input  logic          clock,
	input  logic          reset,
	rv_bus_if.master      bus,
	output rv_pkg::inst_t inst,
	output logic [31:0]   pc,
	input  logic [31:0]   exu_result,
	input  logic [31:0]   exu_mem_addr,
	input  logic [31:0]   next_pc,
	output logic          rf_wen,
	output logic [31:0]   rf_wdata,
	input  logic [31:0]   store_data,
	output logic          retire_valid,
	output logic [31:0]   retire_pc,
	output logic          trap
);
	import rv_pkg::*;

	ctrl_state_e state;
	opcode_e     opcode;
	logic        is_load;
	logic        is_store;
	logic        is_mem;
	logic        writes_rd;
	logic        issue_fetch;
	logic        rsp_fire;
	logic [31:0] load_data;

	assign opcode = opcode_e'(inst.r.opcode);
	assign is_load = (opcode == OP_LOAD);
	assign is_store = (opcode == OP_STORE);
	assign is_mem = is_load || is_store;
	assign writes_rd = (opcode == OP_LUI) || (opcode == OP_IMM) || (opcode == OP_REG) ||
		(opcode == OP_JAL);

	assign retire_valid = ((state == EXECUTE) && !is_mem) || (state == WRITEBACK);
	assign retire_pc = pc;
	assign trap = (state == HALT);
	assign rf_wen = ((state == EXECUTE) && writes_rd) || ((state == WRITEBACK) && is_load);
	assign rf_wdata = (state == WRITEBACK) ? load_data : exu_result;

	assign bus.rsp_ready = (state == WAIT_INST) || (state == MEM_WAIT);
	assign rsp_fire = bus.rsp_valid && bus.rsp_ready;
	assign issue_fetch = (state == FETCH) || retire_valid; // Next fetch leaves on retire.

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FETCH;
			pc <= reset_pc;
			bus.req_valid <= 1'b0;
		end else begin
			if (bus.req_valid && bus.req_ready)
				bus.req_valid <= 1'b0;
			case (state)
				FETCH: begin
					bus.req_valid <= 1'b1;
					state <= WAIT_INST;
				end
				WAIT_INST: begin
					if (rsp_fire && bus.err)
						state <= HALT;
					else if (rsp_fire)
						state <= EXECUTE;
				end
				EXECUTE: begin
					bus.req_valid <= 1'b1;
					if (is_mem) begin
						state <= MEM_REQ;
					end else begin
						pc <= next_pc;
						state <= WAIT_INST;
					end
				end
				MEM_REQ: begin
					if (bus.req_ready)
						state <= MEM_WAIT;
				end
				MEM_WAIT: begin
					if (rsp_fire && bus.err)
						state <= HALT;
					else if (rsp_fire)
						state <= WRITEBACK;
				end
				WRITEBACK: begin
					pc <= next_pc;
					bus.req_valid <= 1'b1;
					state <= WAIT_INST;
				end
				default: state <= HALT; // Only reset leaves HALT.
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (issue_fetch) begin
			bus.addr <= (state == FETCH) ? pc : next_pc;
			bus.write <= 1'b0;
			bus.wstrb <= 4'h0;
		end else if ((state == EXECUTE) && is_mem) begin
			bus.addr <= exu_mem_addr;
			bus.write <= is_store;
			bus.wstrb <= is_store ? 4'hf : 4'h0;
			bus.wdata <= store_data;
		end
		if (rsp_fire && (state == WAIT_INST))
			inst <= bus.rdata;
		if (rsp_fire && (state == MEM_WAIT))
			load_data <= bus.rdata;
	end

endmodule

`default_nettype wire

//--- rv_exu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exu (
	input  rv_pkg::inst_t inst,
	input  logic [31:0]   pc,
	input  logic [31:0]   src1,
	input  logic [31:0]   src2,
	output logic [31:0]   result,
	output logic [31:0]   mem_addr,
	output logic [31:0]   next_pc
);
	import rv_pkg::*;

	opcode_e     opcode;
	alu_op_e     alu_op;
	logic [31:0] imm;
	logic [31:0] operand_b;
	logic [31:0] alu_out;
	logic [31:0] pc_plus4;
	logic        taken;

	assign opcode = opcode_e'(inst.r.opcode);

	always_comb begin
		case (opcode)
			OP_LUI:    imm = {inst.raw[31:12], 12'h000};
			OP_STORE:  imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
			OP_BRANCH: imm = {{20{inst.raw[31]}}, inst.raw[7], inst.raw[30:25], inst.raw[11:8], 1'b0};
			OP_JAL:    imm = {{12{inst.raw[31]}}, inst.raw[19:12], inst.raw[20], inst.raw[30:21], 1'b0};
			default:   imm = {{20{inst.i.imm12[11]}}, inst.i.imm12};
		endcase
	end

	always_comb begin
		alu_op = ADD;
		if (opcode == OP_LUI) begin
			alu_op = PASS_B;
		end else if ((opcode == OP_REG) || (opcode == OP_IMM)) begin
			case (inst.r.funct3)
				3'b000: alu_op = ((opcode == OP_REG) && inst.r.funct7[5]) ? SUB : ADD;
				3'b100: alu_op = XOR;
				3'b110: alu_op = OR;
				3'b111: alu_op = AND;
				default: alu_op = ADD;
			endcase
		end
	end

	assign operand_b = (opcode == OP_REG) ? src2 : imm;

	always_comb begin
		case (alu_op)
			SUB:     alu_out = src1 - operand_b;
			AND:     alu_out = src1 & operand_b;
			OR:      alu_out = src1 | operand_b;
			XOR:     alu_out = src1 ^ operand_b;
			PASS_B:  alu_out = operand_b;
			default: alu_out = src1 + operand_b;
		endcase
	end

	assign pc_plus4 = pc + 32'd4;
	assign taken = (opcode == OP_BRANCH) && ((src1 == src2) != inst.r.funct3[0]); // BNE has funct3[0] set.
	assign result = (opcode == OP_JAL) ? pc_plus4 : alu_out;
	assign mem_addr = src1 + imm;
	assign next_pc = ((opcode == OP_JAL) || taken) ? pc + imm : pc_plus4;

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;

	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		FETCH,
		WAIT_INST,
		EXECUTE,
		MEM_REQ,
		MEM_WAIT,
		WRITEBACK,
		HALT
	} ctrl_state_e;

	// B, U and J immediates are scattered, so they are cut from the raw view.
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
		logic [xlen-1:0] raw;
	} inst_t;

endpackage

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  logic        clock,
	input  logic [4:0]  raddr1,
	input  logic [4:0]  raddr2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2,
	input  logic        wen,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata
);

	logic [31:0] regs [32];

	assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1]; // x0 always reads zero.
	assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

	always_ff @(posedge clock) begin
		if (wen && (waddr != 5'd0))
			regs[waddr] <= wdata;
	end

endmodule

`default_nettype wire

//--- rv_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module rv_xbar #(
	parameter logic [31:0] clint_base = 32'h0200_0000
) (
	input  logic        clock,
	input  logic        reset,
	rv_bus_if.slave     core_bus,
	rv_bus_if.master    clint_bus,
	output logic        awvalid,
	input  logic        awready,
	output logic [31:0] awaddr,
	output logic        wvalid,
	input  logic        wready,
	output logic [31:0] wdata,
	output logic [3:0]  wstrb,
	input  logic        bvalid,
	output logic        bready,
	input  logic [1:0]  bresp,
	output logic        arvalid,
	input  logic        arready,
	output logic [31:0] araddr,
	input  logic        rvalid,
	output logic        rready,
	input  logic [31:0] rdata,
	input  logic [1:0]  rresp
);

	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_clint_req = 3'd1;
	localparam logic [2:0] st_clint_rsp = 3'd2;
	localparam logic [2:0] st_read = 3'd3;
	localparam logic [2:0] st_write = 3'd4;
	localparam logic [2:0] st_resp = 3'd5;

	logic [2:0]  state;
	logic [31:0] clint_off;
	logic [31:0] req_addr;
	logic        req_write;
	logic [31:0] req_wdata;
	logic [3:0]  req_wstrb;
	logic [31:0] rsp_data;
	logic        rsp_err;

	assign clint_off = core_bus.addr - clint_base; // Wraps high for addresses below the base.

	assign core_bus.req_ready = (state == st_idle);
	assign core_bus.rsp_valid = (state == st_resp);
	assign core_bus.rdata = rsp_data;
	assign core_bus.err = rsp_err;

	assign clint_bus.req_valid = (state == st_clint_req);
	assign clint_bus.addr = req_addr;
	assign clint_bus.write = req_write;
	assign clint_bus.wdata = req_wdata;
	assign clint_bus.wstrb = req_wstrb;
	assign clint_bus.rsp_ready = (state == st_clint_rsp);

	assign awaddr = req_addr;
	assign araddr = req_addr;
	assign wdata = req_wdata;
	assign wstrb = req_wstrb;
	assign bready = (state == st_write) && !awvalid && !wvalid; // Both write channels are done.
	assign rready = (state == st_read) && !arvalid;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			arvalid <= 1'b0;
		end else begin
			if (awvalid && awready)
				awvalid <= 1'b0;
			if (wvalid && wready)
				wvalid <= 1'b0;
			if (arvalid && arready)
				arvalid <= 1'b0;
			case (state)
				st_idle: begin
					if (core_bus.req_valid && (clint_off < 32'd16)) begin
						state <= st_clint_req;
					end else if (core_bus.req_valid && core_bus.write) begin
						state <= st_write;
						awvalid <= 1'b1;
						wvalid <= 1'b1;
					end else if (core_bus.req_valid) begin
						state <= st_read;
						arvalid <= 1'b1;
					end
				end
				st_clint_req: if (clint_bus.req_ready) state <= st_clint_rsp;
				st_clint_rsp: if (clint_bus.rsp_valid) state <= st_resp;
				st_read: if (rvalid && rready) state <= st_resp;
				st_write: if (bvalid && bready) state <= st_resp;
				st_resp: if (core_bus.rsp_ready) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (core_bus.req_valid && core_bus.req_ready) begin
			req_addr <= core_bus.addr;
			req_write <= core_bus.write;
			req_wdata <= core_bus.wdata;
			req_wstrb <= core_bus.wstrb;
		end
		if (clint_bus.rsp_valid && clint_bus.rsp_ready) begin
			rsp_data <= clint_bus.rdata;
			rsp_err <= clint_bus.err;
		end else if (rvalid && rready) begin
			rsp_data <= rdata;
			rsp_err <= (rresp != 2'b00);
		end else if (bvalid && bready) begin
			rsp_data <= 32'd0;
			rsp_err <= (bresp != 2'b00);
		end
	end

endmodule

`default_nettype wire

//--- tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

	localparam logic [31:0] reset_pc = 32'h3000_0000;
	localparam logic [31:0] clint_base = 32'h0200_0000;
	localparam logic [31:0] final_addr = reset_pc + 32'h1fc;
	localparam logic [31:0] data_word = 32'h5a5a_0fff;
	localparam logic [31:0] const_a = 32'h0000_0123;
	localparam logic [31:0] const_b = 32'hffff_ffaa; // ADDI immediate 12'hfaa, sign-extended.
	localparam int timer_gap = 2; // Retires from the first mtime load to the second.
	localparam logic [6:0] op_lui = 7'h37;
	localparam logic [6:0] op_imm = 7'h13;
	localparam logic [6:0] op_reg = 7'h33;
	localparam logic [6:0] op_load = 7'h03;

	logic        clock;
	logic        reset;
	logic        awvalid;
	logic        awready;
	logic [31:0] awaddr;
	logic        wvalid;
	logic        wready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        bvalid;
	logic        bready;
	logic [1:0]  bresp;
	logic        arvalid;
	logic        arready;
	logic [31:0] araddr;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        retire_valid;
	logic [31:0] retire_pc;
	logic        trap;

	logic [31:0] mem [logic [31:0]];
	logic [31:0] exp_store [logic [31:0]];
	logic [31:0] exp_retire [$];
	logic [31:0] lfsr = 32'h71f724a2;
	logic [31:0] pc_fill;
	logic [31:0] mtime_first;
	logic [31:0] mtime_second;
	int          prog_words = 0;
	int          timer_stores = 0;
	bit          final_store_seen = 1'b0;

	rv_core_top #(
		.reset_pc(reset_pc),
		.clint_base(clint_base)
	) dut_i (.*);

	bind rv_core_top rv_core_asserts asserts_i (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic lfsr_step();
		logic out;
		out = lfsr[0];
		lfsr = (lfsr >> 1) ^ (out ? 32'ha300_0000 : 32'h0);
		return out;
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h0bad_f00d;
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
		return {funct7, rs2, rs1, funct3, rd, op_reg};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] op, input logic [4:0] rd,
		input logic [2:0] funct3, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, funct3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] b_type(input logic [2:0] funct3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	task automatic stop_fail(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic random_wait();
		int cycles;
		cycles = lfsr_step();
		cycles = cycles * 2 + lfsr_step();
		repeat (cycles) begin
			@(posedge clock);
			#1; // Each waited cycle ends 1 ns after its edge.
		end
	endtask

	task automatic place(input logic [31:0] word, input bit runs);
		mem[pc_fill] = word;
		if (runs)
			exp_retire.push_back(pc_fill);
		pc_fill = pc_fill + 32'd4;
		prog_words++;
	endtask

	task automatic load_program();
		logic [31:0] jal_link;
		pc_fill = reset_pc;
		mem[reset_pc + 32'h100] = data_word;
		place({reset_pc[31:12], 5'd1, op_lui}, 1'b1); // x1 holds the data base.
		place(i_type(op_imm, 5'd2, 3'b000, 5'd0, const_a[11:0]), 1'b1);
		place(i_type(op_imm, 5'd3, 3'b000, 5'd0, const_b[11:0]), 1'b1);
		place(r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd4), 1'b1);
		place(s_type(5'd4, 5'd1, 12'h180), 1'b1);
		place(r_type(7'h20, 5'd3, 5'd2, 3'b000, 5'd5), 1'b1);
		place(s_type(5'd5, 5'd1, 12'h184), 1'b1);
		place(r_type(7'h00, 5'd3, 5'd2, 3'b111, 5'd6), 1'b1);
		place(s_type(5'd6, 5'd1, 12'h188), 1'b1);
		place(r_type(7'h00, 5'd3, 5'd2, 3'b110, 5'd7), 1'b1);
		place(s_type(5'd7, 5'd1, 12'h18c), 1'b1);
		place(r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd8), 1'b1);
		place(s_type(5'd8, 5'd1, 12'h190), 1'b1);
		place(s_type(5'd1, 5'd1, 12'h194), 1'b1);
		place(i_type(op_load, 5'd10, 3'b010, 5'd1, 12'h100), 1'b1);
		place(i_type(op_imm, 5'd10, 3'b000, 5'd10, 12'h001), 1'b1);
		place(s_type(5'd10, 5'd1, 12'h198), 1'b1);
		place(b_type(3'b000, 5'd2, 5'd3, 13'd8), 1'b1); // BEQ falls through.
		place(b_type(3'b001, 5'd2, 5'd3, 13'd8), 1'b1);
		place(i_type(op_imm, 5'd2, 3'b000, 5'd0, 12'h000), 1'b0);
		jal_link = pc_fill + 32'd4;
		place(j_type(5'd11, 21'd8), 1'b1);
		place(i_type(op_imm, 5'd2, 3'b000, 5'd0, 12'h000), 1'b0);
		place(b_type(3'b000, 5'd2, 5'd2, 13'd8), 1'b1);
		place(i_type(op_imm, 5'd2, 3'b000, 5'd0, 12'h000), 1'b0);
		place(s_type(5'd11, 5'd1, 12'h19c), 1'b1);
		place(s_type(5'd2, 5'd1, 12'h1a0), 1'b1); // Still const_a only if every skip worked.
		place({clint_base[31:12], 5'd9, op_lui}, 1'b1);
		place(i_type(op_load, 5'd12, 3'b010, 5'd9, 12'h000), 1'b1);
		place(i_type(op_imm, 5'd0, 3'b000, 5'd0, 12'h000), 1'b1);
		place(i_type(op_load, 5'd13, 3'b010, 5'd9, 12'h000), 1'b1);
		place(s_type(5'd12, 5'd1, 12'h1a4), 1'b1);
		place(s_type(5'd13, 5'd1, 12'h1a8), 1'b1);
		place(s_type(5'd2, 5'd1, 12'h1fc), 1'b0); // Gets bresp 2 and never retires.
		exp_store[reset_pc + 32'h180] = const_a + const_b;
		exp_store[reset_pc + 32'h184] = const_a - const_b;
		exp_store[reset_pc + 32'h188] = const_a & const_b;
		exp_store[reset_pc + 32'h18c] = const_a | const_b;
		exp_store[reset_pc + 32'h190] = const_a ^ const_b;
		exp_store[reset_pc + 32'h194] = {reset_pc[31:12], 12'h000};
		exp_store[reset_pc + 32'h198] = data_word + 32'd1;
		exp_store[reset_pc + 32'h19c] = jal_link;
		exp_store[reset_pc + 32'h1a0] = const_a;
	endtask

	task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
		if (addr == final_addr) begin
			final_store_seen = 1'b1;
		end else if (addr == reset_pc + 32'h1a4) begin
			mtime_first = data;
			timer_stores++;
		end else if (addr == reset_pc + 32'h1a8) begin
			mtime_second = data;
			timer_stores++;
		end else if (!exp_store.exists(addr)) begin
			stop_fail("The core stored to an address that the program never writes.");
		end else begin
			assert (data == exp_store[addr]) else begin
				$display("MISMATCH time=%0t wdata at %h: expected %h, got %h", $time, addr,
					exp_store[addr], data);
				stop_fail("A stored result is wrong.");
			end
			exp_store.delete(addr);
		end
	endtask

	always begin : axi_write
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
		@(posedge clock);
		if (awvalid && !reset) begin
			#1;
			random_wait();
			awready = 1'b1;
			@(posedge clock);
			addr = awaddr;
			#1 awready = 1'b0;
			random_wait();
			wready = 1'b1;
			@(posedge clock);
			data = wdata;
			strb = wstrb;
			#1 wready = 1'b0;
			assert (strb == 4'hf) else begin
				$display("MISMATCH time=%0t wstrb at %h: expected %h, got %h", $time, addr,
					4'hf, strb);
				stop_fail("A store did not write the full word.");
			end
			check_store(addr, data);
			mem[addr] = data;
			random_wait();
			bvalid = 1'b1;
			bresp = (addr == final_addr) ? 2'b10 : 2'b00;
			do @(posedge clock); while (!bready);
			#1 bvalid = 1'b0;
			bresp = 2'b00;
		end
	end

	always begin : axi_read
		logic [31:0] addr;
		@(posedge clock);
		if (arvalid && !reset) begin
			#1;
			random_wait();
			arready = 1'b1;
			@(posedge clock);
			addr = araddr;
			#1 arready = 1'b0;
			random_wait();
			rvalid = 1'b1;
			rdata = mem.exists(addr) ? mem[addr] : fill_word(addr);
			rresp = 2'b00;
			do @(posedge clock); while (!rready);
			#1 rvalid = 1'b0;
		end
	end

	always @(posedge clock) begin
		if (!reset && retire_valid) begin
			assert (exp_retire.size() != 0) else
				stop_fail("The core retired more instructions than the program runs.");
			assert (retire_pc == exp_retire[0]) else begin
				$display("MISMATCH time=%0t retire_pc: expected %h, got %h", $time,
					exp_retire[0], retire_pc);
				stop_fail("An instruction retired out of program order.");
			end
			void'(exp_retire.pop_front());
		end
	end

	always @(posedge clock) begin
		if (dut_i.asserts_i.fail_count != 0)
			stop_fail("A bus or retire assertion bound to the DUT failed.");
	end

	initial begin
		@(negedge reset);
		repeat (prog_words * 40 + 60) @(posedge clock);
		stop_fail("Timeout: the program did not finish within its cycle budget.");
	end

	initial begin
		reset = 1'b1;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bresp = 2'b00;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = 32'd0;
		rresp = 2'b00;
		load_program();
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;
		wait (final_store_seen);
		while (!trap) @(posedge clock);
		repeat (50) @(posedge clock); // Bound checks watch for requests after the trap.
		assert (exp_store.num() == 0) else stop_fail("Some expected stores never happened.");
		assert (exp_retire.size() == 0) else stop_fail("Some instructions never retired.");
		assert (timer_stores == 2) else stop_fail("The two mtime stores were not both seen.");
		assert (mtime_second >= mtime_first + timer_gap) else begin
			$display("MISMATCH time=%0t mtime delta: expected at least %0d, got %0d", $time,
				timer_gap, mtime_second - mtime_first);
			stop_fail("The timer did not advance between the two loads.");
		end
		if (dut_i.asserts_i.fail_count == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			stop_fail("A bound assertion failed late in the run.");
		end
	end

endmodule

`default_nettype wire
